//--- design/mem_intf.sv
`timescale 1ns/100ps

interface mem_req_intf #(
    parameter int ID_WIDTH = mem_pkg::ID_WIDTH
);
    import mem_pkg::*;

    logic                  valid;
    logic                  ready;
    logic                  read_enable;
    logic [MASK_WIDTH-1:0] write_enable;   // byte mask, zero for a pure read
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
    logic [ID_WIDTH-1:0]   id;
    logic                  last;

    modport in (
        input  valid, read_enable, write_enable, addr, data, id, last,
        output ready
    );

    modport out (
        output valid, read_enable, write_enable, addr, data, id, last,
        input  ready
    );

endinterface

interface mem_resp_intf #(
    parameter int ID_WIDTH = mem_pkg::ID_WIDTH
);
    import mem_pkg::*;

    logic                  valid;
    logic                  ready;
    logic [DATA_WIDTH-1:0] data;
    logic [ID_WIDTH-1:0]   id;

    modport in (
        input  valid, data, id,
        output ready
    );

    modport out (
        output valid, data, id,
        input  ready
    );

endinterface

//--- design/mem_merge.sv
`timescale 1ns/100ps

module mem_merge (
    input  logic       clk,
    input  logic       rst_n,
    mem_req_intf.in    mem_in [mem_pkg::PORTS],
    mem_req_intf.out   mem_out,
    input  logic       full
);
    import mem_pkg::*;

    logic [PORTS-1:0]        in_valid;
    logic [PORTS-1:0]        in_last;
    logic [PORTS-1:0]        in_read;
    logic [MASK_WIDTH-1:0]   in_mask [PORTS];
    logic [ADDR_WIDTH-1:0]   in_addr [PORTS];
    logic [DATA_WIDTH-1:0]   in_data [PORTS];
    logic [PRE_ID_WIDTH-1:0] in_id [PORTS];

    logic [PORTS-1:0]        grant;
    logic                    take;
    logic                    load_ok;
    logic                    sel_block;

    logic                    sel_valid;
    logic                    sel_read;
    logic [MASK_WIDTH-1:0]   sel_mask;
    logic [ADDR_WIDTH-1:0]   sel_addr;
    logic [DATA_WIDTH-1:0]   sel_data;
    logic [PRE_ID_WIDTH-1:0] sel_id;
    logic                    sel_last;
    logic [PORT_WIDTH-1:0]   sel_port;

    logic                    out_valid;
    logic                    out_read;
    logic [MASK_WIDTH-1:0]   out_mask;
    logic [ADDR_WIDTH-1:0]   out_addr;
    logic [DATA_WIDTH-1:0]   out_data;
    logic [ID_WIDTH-1:0]     out_id;
    logic                    out_last;

    for (genvar k = 0; k < PORTS; k++) begin : g_port
        assign in_valid[k] = mem_in[k].valid;
        assign in_last[k] = mem_in[k].last;
        assign in_read[k] = mem_in[k].read_enable;
        assign in_mask[k] = mem_in[k].write_enable;
        assign in_addr[k] = mem_in[k].addr;
        assign in_data[k] = mem_in[k].data;
        assign in_id[k] = mem_in[k].id;
        assign mem_in[k].ready = grant[k] && load_ok && !sel_block;   // only the winner sees ready
    end

    always_comb begin
        sel_valid = 1'b0;
        sel_read = 1'b0;
        sel_mask = '0;
        sel_addr = '0;
        sel_data = '0;
        sel_id = '0;
        sel_last = 1'b0;
        sel_port = '0;
        for (int k = 0; k < PORTS; k++) begin
            if (grant[k]) begin
                sel_valid = in_valid[k];
                sel_read = in_read[k];
                sel_mask = in_mask[k];
                sel_addr = in_addr[k];
                sel_data = in_data[k];
                sel_id = in_id[k];
                sel_last = in_last[k];
                sel_port = PORT_WIDTH'(k);
            end
        end
    end

    assign load_ok = !out_valid || mem_out.ready;   // empty, or draining this cycle
    assign sel_block = sel_read && full;            // writes still pass at the read limit
    assign take = sel_valid && load_ok && !sel_block;

    merge_arbiter u_arbiter (
        .clk,
        .rst_n,
        .req_valid(in_valid),
        .req_last(in_last),
        .take,
        .grant
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (mem_out.ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_read <= sel_read;
            out_mask <= sel_mask;
            out_addr <= sel_addr;
            out_data <= sel_data;
            out_id <= {sel_port, sel_id};
            out_last <= sel_last;
        end
    end

    assign mem_out.valid = out_valid;
    assign mem_out.read_enable = out_read;
    assign mem_out.write_enable = out_mask;
    assign mem_out.addr = out_addr;
    assign mem_out.data = out_data;
    assign mem_out.id = out_id;
    assign mem_out.last = out_last;

endmodule

//--- design/mem_pkg.sv
package mem_pkg;

    localparam int ADDR_WIDTH = 8;
    localparam int DATA_WIDTH = 32;
    localparam int MASK_WIDTH = DATA_WIDTH / 8;   // one enable per byte lane
    localparam int DEPTH = 2 ** ADDR_WIDTH;

    localparam int PORTS = 2;
    localparam int PORT_WIDTH = (PORTS > 1) ? $clog2(PORTS) : 1;

    localparam int PRE_ID_WIDTH = 2;                        // id as seen by a requester
    localparam int ID_WIDTH = PRE_ID_WIDTH + PORT_WIDTH;    // port index sits on top

    localparam int MAX_OUTSTANDING = 4;
    localparam int CNT_WIDTH = $clog2(MAX_OUTSTANDING + 1);

    // hold the grant on one port until its burst ends
    localparam bit BURST_LOCK = 1'b1;

    typedef enum logic {
        ARB_IDLE,
        ARB_LOCKED
    } arb_state_t;

endpackage

//--- design/mem_ram.sv
`timescale 1ns/100ps

module mem_ram (
    input  logic      clk,
    input  logic      rst_n,
    mem_req_intf.in   req,
    mem_resp_intf.out resp,
    output logic      read_accept
);
    import mem_pkg::*;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    logic                  accept;
    logic                  resp_valid;
    logic [DATA_WIDTH-1:0] resp_data;
    logic [ID_WIDTH-1:0]   resp_id;

    // a beat is taken only when the response slot is free or leaving
    assign req.ready = !resp_valid || resp.ready;
    assign accept = req.valid && req.ready;
    assign read_accept = accept && req.read_enable;

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int b = 0; b < MASK_WIDTH; b++) begin
                if (req.write_enable[b]) begin
                    mem[req.addr][8*b +: 8] <= req.data[8*b +: 8];
                end
            end
        end
    end

    // the read samples the word before any write of the same beat lands
    always_ff @(posedge clk) begin
        if (read_accept) begin
            resp_data <= mem[req.addr];
            resp_id <= req.id;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else if (read_accept) begin
            resp_valid <= 1'b1;
        end else if (resp.ready) begin
            resp_valid <= 1'b0;
        end
    end

    assign resp.valid = resp_valid;
    assign resp.data = resp_data;
    assign resp.id = resp_id;

endmodule

//--- design/mem_subsystem.sv
`timescale 1ns/100ps

module mem_subsystem (
    input  logic                             clk,
    input  logic                             rst_n,

    input  logic                             req0_valid,
    output logic                             req0_ready,
    input  logic                             req0_read_enable,
    input  logic [mem_pkg::MASK_WIDTH-1:0]   req0_write_enable,
    input  logic [mem_pkg::ADDR_WIDTH-1:0]   req0_addr,
    input  logic [mem_pkg::DATA_WIDTH-1:0]   req0_data,
    input  logic [mem_pkg::PRE_ID_WIDTH-1:0] req0_id,
    input  logic                             req0_last,

    input  logic                             req1_valid,
    output logic                             req1_ready,
    input  logic                             req1_read_enable,
    input  logic [mem_pkg::MASK_WIDTH-1:0]   req1_write_enable,
    input  logic [mem_pkg::ADDR_WIDTH-1:0]   req1_addr,
    input  logic [mem_pkg::DATA_WIDTH-1:0]   req1_data,
    input  logic [mem_pkg::PRE_ID_WIDTH-1:0] req1_id,
    input  logic                             req1_last,

    output logic                             rsp0_valid,
    input  logic                             rsp0_ready,
    output logic [mem_pkg::DATA_WIDTH-1:0]   rsp0_data,
    output logic [mem_pkg::PRE_ID_WIDTH-1:0] rsp0_id,

    output logic                             rsp1_valid,
    input  logic                             rsp1_ready,
    output logic [mem_pkg::DATA_WIDTH-1:0]   rsp1_data,
    output logic [mem_pkg::PRE_ID_WIDTH-1:0] rsp1_id
);
    import mem_pkg::*;

    logic [PORTS-1:0]        rsp_valid;
    logic [PORTS-1:0]        rsp_ready;
    logic [DATA_WIDTH-1:0]   rsp_data [PORTS];
    logic [PRE_ID_WIDTH-1:0] rsp_id [PORTS];
    logic                    full;
    logic                    read_accept;
    logic                    read_done;

    mem_req_intf #(.ID_WIDTH(PRE_ID_WIDTH)) req_if [PORTS] ();
    mem_req_intf  merged_if ();
    mem_resp_intf resp_if ();

    assign req_if[0].valid = req0_valid;
    assign req_if[0].read_enable = req0_read_enable;
    assign req_if[0].write_enable = req0_write_enable;
    assign req_if[0].addr = req0_addr;
    assign req_if[0].data = req0_data;
    assign req_if[0].id = req0_id;
    assign req_if[0].last = req0_last;
    assign req0_ready = req_if[0].ready;

    assign req_if[1].valid = req1_valid;
    assign req_if[1].read_enable = req1_read_enable;
    assign req_if[1].write_enable = req1_write_enable;
    assign req_if[1].addr = req1_addr;
    assign req_if[1].data = req1_data;
    assign req_if[1].id = req1_id;
    assign req_if[1].last = req1_last;
    assign req1_ready = req_if[1].ready;

    assign rsp_ready = {rsp1_ready, rsp0_ready};
    assign rsp0_valid = rsp_valid[0];
    assign rsp0_data = rsp_data[0];
    assign rsp0_id = rsp_id[0];
    assign rsp1_valid = rsp_valid[1];
    assign rsp1_data = rsp_data[1];
    assign rsp1_id = rsp_id[1];

    mem_merge u_merge (
        .clk,
        .rst_n,
        .mem_in(req_if),
        .mem_out(merged_if),
        .full
    );

    outstanding_counter u_outstanding (
        .clk,
        .rst_n,
        .read_accept,
        .read_done,
        .full
    );

    mem_ram u_ram (
        .clk,
        .rst_n,
        .req(merged_if),
        .resp(resp_if),
        .read_accept
    );

    resp_route u_route (
        .resp(resp_if),
        .rsp_valid,
        .rsp_data,
        .rsp_id,
        .rsp_ready,
        .read_done
    );

endmodule

//--- design/merge_arbiter.sv
`timescale 1ns/100ps

module merge_arbiter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [mem_pkg::PORTS-1:0] req_valid,
    input  logic [mem_pkg::PORTS-1:0] req_last,
    input  logic                      take,
    output logic [mem_pkg::PORTS-1:0] grant
);
    import mem_pkg::*;

    arb_state_t            state;
    logic [PORTS-1:0]      lock_grant;
    logic [PORTS-1:0]      rr_grant;
    logic [PORT_WIDTH-1:0] last_port;
    logic [PORT_WIDTH-1:0] grant_port;
    logic                  take_last;

    // first valid port after the one served last
    always_comb begin
        logic found;
        int   idx;
        found = 1'b0;
        rr_grant = '0;
        for (int i = 1; i <= PORTS; i++) begin
            idx = (int'(last_port) + i) % PORTS;
            if (!found && req_valid[idx]) begin
                rr_grant[idx] = 1'b1;
                found = 1'b1;
            end
        end
    end

    assign grant = (state == ARB_LOCKED) ? lock_grant : rr_grant;
    assign take_last = |(grant & req_last);

    always_comb begin
        grant_port = '0;
        for (int k = 0; k < PORTS; k++) begin
            if (grant[k]) grant_port = PORT_WIDTH'(k);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
            lock_grant <= '0;
            last_port <= PORT_WIDTH'(PORTS - 1);   // port 0 wins the first round
        end else if (take) begin
            last_port <= grant_port;
            case (state)
                ARB_IDLE: begin
                    if (BURST_LOCK && !take_last) begin
                        state <= ARB_LOCKED;
                        lock_grant <= grant;
                    end
                end
                ARB_LOCKED: begin
                    if (take_last) state <= ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

//--- design/outstanding_counter.sv
`timescale 1ns/100ps

module outstanding_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic read_accept,
    input  logic read_done,
    output logic full
);
    import mem_pkg::*;

    logic [CNT_WIDTH-1:0] count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({read_accept, read_done})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither leave it alone
            endcase
        end
    end

    assign full = (count >= CNT_WIDTH'(MAX_OUTSTANDING));

endmodule

//--- design/resp_route.sv
`timescale 1ns/100ps

module resp_route (
    mem_resp_intf.in                             resp,
    output logic [mem_pkg::PORTS-1:0]            rsp_valid,
    output logic [mem_pkg::DATA_WIDTH-1:0]       rsp_data [mem_pkg::PORTS],
    output logic [mem_pkg::PRE_ID_WIDTH-1:0]     rsp_id [mem_pkg::PORTS],
    input  logic [mem_pkg::PORTS-1:0]            rsp_ready,
    output logic                                 read_done
);
    import mem_pkg::*;

    logic [PORT_WIDTH-1:0] dest;

    assign dest = resp.id[ID_WIDTH-1 -: PORT_WIDTH];   // port index rides on top of the id

    for (genvar k = 0; k < PORTS; k++) begin : g_port
        assign rsp_valid[k] = resp.valid && (dest == PORT_WIDTH'(k));
        assign rsp_data[k] = resp.data;
        assign rsp_id[k] = resp.id[PRE_ID_WIDTH-1:0];
    end

    assign resp.ready = rsp_ready[dest];
    assign read_done = resp.valid && resp.ready;

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f verilog.f -o Vtb_top
./obj_dir/Vtb_top 2>&1 | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
    exit 1
fi
# a run stopped by an assertion prints neither message
grep -qF '*** TEST PASSED ***' sim.log

//--- tests/mem_subsystem_assertions.sv
`timescale 1ns/100ps

module mem_subsystem_assertions (
    input logic                          clk,
    input logic                          rst_n,
    input logic [mem_pkg::PORTS-1:0]     grant,
    input logic                          take,
    input logic                          last,
    input logic [mem_pkg::CNT_WIDTH-1:0] count,
    input logic                          read_accept,
    input logic                          read_done
);
    import mem_pkg::*;

    logic             locked;
    logic [PORTS-1:0] held_grant;

    // shadow of the burst lock, taken from the beats that pass
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            locked <= 1'b0;
            held_grant <= '0;
        end else if (take) begin
            if (!locked) held_grant <= grant;
            locked <= !last;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) locked |-> grant == held_grant)
        else $error("grant moved to another port inside a burst");

    assert property (@(posedge clk) disable iff (!rst_n) take |-> $onehot(grant))
        else $error("beat taken without a one-hot grant");

    assert property (@(posedge clk) disable iff (!rst_n) count <= CNT_WIDTH'(MAX_OUTSTANDING))
        else $error("outstanding count above the limit");

    assert property (@(posedge clk) disable iff (!rst_n)
        (read_done && !read_accept) |-> count != '0)
        else $error("read completed with no read in flight");

endmodule

bind mem_merge mem_subsystem_assertions u_merge_checks (
    .clk, .rst_n, .grant, .take, .last(sel_last),
    .count('0), .read_accept(1'b0), .read_done(1'b0)
);

bind outstanding_counter mem_subsystem_assertions u_counter_checks (
    .clk, .rst_n, .grant('0), .take(1'b0), .last(1'b0),
    .count, .read_accept, .read_done
);

//--- tests/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

//--- tests/tb_top.sv
`timescale 1ns/100ps

module tb_top;
    import mem_pkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int BURSTS = 12;   // per port in the mixed traffic phase
    localparam int ISSUED_BEATS = DEPTH + 2 + 40 + 2 * BURSTS * 4 + MAX_OUTSTANDING + 3 + 1;
    localparam int CYCLE_LIMIT = 20 * ISSUED_BEATS + RESET_CYCLES;
    localparam int ENTRY_WIDTH = PRE_ID_WIDTH + DATA_WIDTH;

    logic clk;
    logic rst_n;
    logic [PORTS-1:0]        req_valid;
    logic [PORTS-1:0]        req_ready;
    logic [PORTS-1:0]        req_read;
    logic [PORTS-1:0]        req_last;
    logic [PORTS-1:0]        rsp_valid;
    logic [PORTS-1:0]        rsp_ready;
    logic [MASK_WIDTH-1:0]   req_mask [PORTS];
    logic [ADDR_WIDTH-1:0]   req_addr [PORTS];
    logic [DATA_WIDTH-1:0]   req_data [PORTS];
    logic [PRE_ID_WIDTH-1:0] req_id [PORTS];
    logic [DATA_WIDTH-1:0]   rsp_data [PORTS];
    logic [PRE_ID_WIDTH-1:0] rsp_id [PORTS];

    logic [DATA_WIDTH-1:0]   model [DEPTH];
    logic [ENTRY_WIDTH-1:0]  expect0 [$];
    logic [ENTRY_WIDTH-1:0]  expect1 [$];
    logic [PORTS-1:0]        held;
    logic [DATA_WIDTH-1:0]   held_data [PORTS];
    logic [PRE_ID_WIDTH-1:0] held_id [PORTS];
    logic [15:0]             lfsr;
    int                      reads_taken;
    int                      responses_seen;
    int                      cycle;
    bit                      traffic_done;

    tb_clock u_clock (.clk, .rst_n);

    mem_subsystem dut (
        .clk, .rst_n,
        .req0_valid(req_valid[0]), .req0_ready(req_ready[0]),
        .req0_read_enable(req_read[0]), .req0_write_enable(req_mask[0]),
        .req0_addr(req_addr[0]), .req0_data(req_data[0]),
        .req0_id(req_id[0]), .req0_last(req_last[0]),
        .req1_valid(req_valid[1]), .req1_ready(req_ready[1]),
        .req1_read_enable(req_read[1]), .req1_write_enable(req_mask[1]),
        .req1_addr(req_addr[1]), .req1_data(req_data[1]),
        .req1_id(req_id[1]), .req1_last(req_last[1]),
        .rsp0_valid(rsp_valid[0]), .rsp0_ready(rsp_ready[0]),
        .rsp0_data(rsp_data[0]), .rsp0_id(rsp_id[0]),
        .rsp1_valid(rsp_valid[1]), .rsp1_ready(rsp_ready[1]),
        .rsp1_data(rsp_data[1]), .rsp1_id(rsp_id[1])
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // taps 16, 14, 13, 11
    endfunction

    // one LFSR step for every bit handed out
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // expected word after a masked write lands on it
    function automatic logic [DATA_WIDTH-1:0] apply_write(input logic [DATA_WIDTH-1:0] old_word,
            input logic [MASK_WIDTH-1:0] mask, input logic [DATA_WIDTH-1:0] wdata);
        logic [DATA_WIDTH-1:0] word;
        word = old_word;
        for (int b = 0; b < MASK_WIDTH; b++) begin
            if (mask[b]) word[8*b +: 8] = wdata[8*b +: 8];
        end
        return word;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] fill_word(input logic [ADDR_WIDTH-1:0] a);
        return {a, ~a, a ^ 8'h5a, a + 8'h33};
    endfunction

    // starts and ends 1 ns after a rising edge
    task automatic send_beat(input int p, input logic rd, input logic [MASK_WIDTH-1:0] mask,
            input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] wdata,
            input logic [PRE_ID_WIDTH-1:0] id, input logic last);
        logic done;
        req_valid[p] = 1'b1;
        req_read[p] = rd;
        req_mask[p] = mask;
        req_addr[p] = addr;
        req_data[p] = wdata;
        req_id[p] = id;
        req_last[p] = last;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = req_ready[p];
            @(posedge clk);
            #1;
        end
        req_valid[p] = 1'b0;
    endtask

    task automatic random_beat(input int p, input logic last);
        logic [1:0]            kind;
        logic                  rd;
        logic [MASK_WIDTH-1:0] mask;
        kind = 2'(random_bits(2));
        rd = kind[0] || (kind == 2'b00);
        mask = kind[1] ? MASK_WIDTH'(random_bits(MASK_WIDTH)) : '0;
        if (!rd && mask == '0) mask = '1;
        // a small shared window so both ports hit the same words
        send_beat(p, rd, mask, ADDR_WIDTH'(8'h40 + random_bits(3)),
            DATA_WIDTH'(random_bits(DATA_WIDTH)), PRE_ID_WIDTH'(random_bits(PRE_ID_WIDTH)), last);
    endtask

    task automatic run_bursts(input int p);
        int len;
        for (int b = 0; b < BURSTS; b++) begin
            len = int'(random_bits(2)) + 1;
            for (int i = 0; i < len; i++) random_beat(p, i == len - 1);
        end
    endtask

    task automatic wait_drained();
        while (expect0.size() != 0 || expect1.size() != 0 || rsp_valid != '0) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic check_response(input int p);
        logic [ENTRY_WIDTH-1:0] entry;
        int                     pending;
        pending = (p == 0) ? expect0.size() : expect1.size();
        assert (pending != 0)
            else abort_run($sformatf("rsp%0d delivered a response with no read pending", p));
        if (p == 0) entry = expect0.pop_front();
        else entry = expect1.pop_front();
        responses_seen++;
        assert (rsp_data[p] === entry[DATA_WIDTH-1:0])
            else abort_run($sformatf("FAIL rsp%0d_data: got %h, expected %h",
                p, rsp_data[p], entry[DATA_WIDTH-1:0]));
        assert (rsp_id[p] === entry[ENTRY_WIDTH-1 -: PRE_ID_WIDTH])
            else abort_run($sformatf("FAIL rsp%0d_id: got %h, expected %h",
                p, rsp_id[p], entry[ENTRY_WIDTH-1 -: PRE_ID_WIDTH]));
    endtask

    // handshakes seen here complete on the next rising edge
    always @(negedge clk) begin
        if (!rst_n) begin
            held = '0;
            reads_taken = 0;
            responses_seen = 0;
        end else begin
            for (int p = 0; p < PORTS; p++) begin
                if (req_valid[p] && req_ready[p]) begin
                    if (req_read[p]) begin
                        if (p == 0) expect0.push_back({req_id[p], model[req_addr[p]]});
                        else expect1.push_back({req_id[p], model[req_addr[p]]});
                        reads_taken++;
                    end
                    model[req_addr[p]] = apply_write(model[req_addr[p]], req_mask[p], req_data[p]);
                end
                if (held[p]) begin
                    assert (rsp_valid[p])
                        else abort_run($sformatf("rsp%0d_valid dropped before the transfer", p));
                    assert (rsp_data[p] === held_data[p])
                        else abort_run($sformatf("FAIL rsp%0d_data: held %h changed to %h",
                            p, held_data[p], rsp_data[p]));
                    assert (rsp_id[p] === held_id[p])
                        else abort_run($sformatf("FAIL rsp%0d_id: held %h changed to %h",
                            p, held_id[p], rsp_id[p]));
                end
                if (rsp_valid[p] && rsp_ready[p]) check_response(p);
                held[p] = rsp_valid[p] && !rsp_ready[p];
                held_data[p] = rsp_data[p];
                held_id[p] = rsp_id[p];
            end
        end
    end

    initial begin
        cycle = 0;
        forever begin
            @(posedge clk);
            cycle++;
            if (cycle > CYCLE_LIMIT)
                abort_run($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    initial begin
        int                    stall_base;
        logic [ADDR_WIDTH-1:0] addr;
        req_valid = '0;
        req_read = '0;
        req_last = '0;
        rsp_ready = '1;
        for (int p = 0; p < PORTS; p++) begin
            req_mask[p] = '0;
            req_addr[p] = '0;
            req_data[p] = '0;
            req_id[p] = '0;
        end
        lfsr = 16'd17338;
        traffic_done = 1'b0;

        @(posedge clk);
        @(negedge clk);
        assert (req_ready == '0 && rsp_valid == '0)
            else abort_run("ready or response valid high during reset");
        assert (dut.u_merge.u_arbiter.state == ARB_IDLE)
            else abort_run("arbiter not idle during reset");
        wait (rst_n == 1'b1);
        @(posedge clk);
        #1;

        for (int a = 0; a < DEPTH; a++) begin
            send_beat(0, 1'b0, '1, ADDR_WIDTH'(a), fill_word(ADDR_WIDTH'(a)), '0, 1'b1);
        end

        addr = ADDR_WIDTH'(random_bits(ADDR_WIDTH));
        send_beat(0, 1'b0, '1, addr, DATA_WIDTH'(random_bits(DATA_WIDTH)), 2'd3, 1'b1);
        send_beat(0, 1'b1, '0, addr, '0, PRE_ID_WIDTH'(random_bits(PRE_ID_WIDTH)), 1'b1);
        wait_drained();

        for (int i = 0; i < 20; i++) begin
            addr = ADDR_WIDTH'(random_bits(ADDR_WIDTH));
            send_beat(i % 2, 1'b0, MASK_WIDTH'(random_bits(MASK_WIDTH)), addr,
                DATA_WIDTH'(random_bits(DATA_WIDTH)), '0, 1'b1);
            send_beat(i % 2, 1'b1, '0, addr, '0, PRE_ID_WIDTH'(i), 1'b1);
        end
        wait_drained();

        fork
            begin
                fork
                    run_bursts(0);
                    run_bursts(1);
                join
                traffic_done = 1'b1;
            end
            begin
                while (!traffic_done) begin
                    rsp_ready = {|random_bits(2), |random_bits(2)};   // ready three times in four
                    @(posedge clk);
                    #1;
                end
                rsp_ready = '1;
            end
        join
        wait_drained();

        rsp_ready = '0;
        stall_base = reads_taken;
        send_beat(0, 1'b1, '0, 8'h10, '0, 2'd1, 1'b1);
        send_beat(1, 1'b0, '1, 8'h11, DATA_WIDTH'(random_bits(DATA_WIDTH)), 2'd2, 1'b1);
        fork
            begin
                for (int i = 0; i <= MAX_OUTSTANDING; i++) begin
                    send_beat(0, 1'b1, '0, ADDR_WIDTH'(8'h12 + i), '0, PRE_ID_WIDTH'(i), 1'b1);
                end
            end
            begin
                repeat (30) @(posedge clk);
                #1;
                assert (reads_taken - stall_base <= MAX_OUTSTANDING)
                    else abort_run("more reads accepted than the outstanding limit");
                rsp_ready = '1;
            end
        join
        wait_drained();

        // the response is first sampled on the second edge after acceptance
        send_beat(1, 1'b1, '0, ADDR_WIDTH'(random_bits(ADDR_WIDTH)), '0, 2'd1, 1'b1);
        @(negedge clk);
        assert (!rsp_valid[1]) else abort_run("read response came one cycle early");
        @(negedge clk);
        assert (rsp_valid[1]) else abort_run("read response missing two cycles after acceptance");
        wait_drained();

        if (responses_seen == reads_taken) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run($sformatf("%0d reads accepted but %0d responses seen",
                reads_taken, responses_seen));
        end
    end

endmodule

//--- verilog.f
design/mem_pkg.sv
design/mem_intf.sv
design/merge_arbiter.sv
design/outstanding_counter.sv
design/mem_merge.sv
design/mem_ram.sv
design/resp_route.sv
design/mem_subsystem.sv
tests/tb_clock.sv
tests/mem_subsystem_assertions.sv
tests/tb_top.sv
